//--- src.f
src/execPkg.sv
src/reservationStation.sv
src/aluUnit.sv
src/cdbArbiter.sv
src/executeCluster.sv
tests/resultChecker.sv
tests/clusterTb.sv

//--- run.sh
#!/bin/sh
# build the execute cluster testbench with verilator and run it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module clusterTb -f src.f -o clusterSim \
    && ./obj_dir/clusterSim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }

//--- tests/clusterTb.sv
`timescale 1ns/1ps

module clusterTb
    import execPkg::*;
();

    localparam int TotalInst = 188;  // alu 76, branch 24, upper and jump 16, chain 40, burst 32.
    localparam int NickCnt   = 1 << NickW;

    logic clk = 1'b0;
    logic rst, rdy, inValid, inReady, src1Ready, src2Ready, cdbValid, cdbTaken;
    logic [DataW-1:0] inPc, inImm, src1Val, src2Val, cdbData, cdbTarget;
    logic [NickW-1:0] inNick, src1Nick, src2Nick, cdbNick;
    opcodeT inOp;
    logic [NickCnt-1:0][DataW-1:0] expData;
    logic [NickCnt-1:0][DataW-1:0] expTarget;
    logic [NickCnt-1:0] expTaken;
    logic [NickCnt-1:0] pending;
    logic acceptFire, fullSeen, stallMode;
    int errCount, tbErrors;

    always #5 clk = ~clk;

    assign acceptFire = inValid && inReady && rdy;

    executeCluster dut0 (.*);

    resultChecker chk0 (.acceptNick(inNick), .*);

    function automatic logic [DataW-1:0] arithShift(input logic [DataW-1:0] v,
                                                    input logic [4:0] sh);
        return (v >> sh) | (v[DataW-1] ? ~({DataW{1'b1}} >> sh) : '0);
    endfunction

    // expected {data, taken, target} from the rv32i rules.
    function automatic logic [2*DataW:0] refExec(input opcodeT op, input logic [DataW-1:0] pc,
                                                 input logic [DataW-1:0] imm,
                                                 input logic [DataW-1:0] a,
                                                 input logic [DataW-1:0] b);
        logic [DataW-1:0] d, tgt, sum, sgn;
        logic             t, hit, lts;
        d   = '0;
        t   = NotJump;
        hit = 1'b0;
        tgt = pc + 4;
        sum = a + imm;
        sgn = {1'b1, {(DataW-1){1'b0}}};
        lts = (a ^ sgn) < (b ^ sgn);  // signed compare via flipped sign bit.
        case (op)
            LUI:   d = imm;
            AUIPC: d = pc + imm;
            JAL:   {d, t, tgt} = {pc + 32'd4, Jump, pc + imm};
            JALR:  {d, t, tgt} = {pc + 32'd4, Jump, sum[DataW-1:1], 1'b0};
            BEQ:   hit = a == b;
            BNE:   hit = a != b;
            BLT:   hit = lts;
            BGE:   hit = !lts;
            BLTU:  hit = a < b;
            BGEU:  hit = a >= b;
            ADDI:  d = sum;
            SLTI:  d = DataW'((a ^ sgn) < (imm ^ sgn));
            SLTIU: d = DataW'(a < imm);
            XORI:  d = a ^ imm;
            ORI:   d = a | imm;
            ANDI:  d = a & imm;
            SLLI:  d = a << imm[4:0];
            SRLI:  d = a >> imm[4:0];
            SRAI:  d = arithShift(a, imm[4:0]);
            ADD:   d = a + b;
            SUB:   d = a - b;
            SLL:   d = a << b[4:0];
            SLT:   d = DataW'(lts);
            SLTU:  d = DataW'(a < b);
            XOR:   d = a ^ b;
            SRL:   d = a >> b[4:0];
            SRA:   d = arithShift(a, b[4:0]);
            OR:    d = a | b;
            AND:   d = a & b;
            default: d = '0;
        endcase
        if (hit) {t, tgt} = {Jump, pc + imm};
        return {d, t, tgt};
    endfunction

    // a random nick still in flight, or -1.
    function automatic int pickDep();
        int start;
        start = $urandom % NickCnt;
        for (int k = 0; k < NickCnt; k++) begin
            if (pending[(start + k) % NickCnt]) return (start + k) % NickCnt;
        end
        return -1;
    endfunction

    // dep of -1 means a ready value, otherwise the producer's nick.
    task automatic sendInst(input opcodeT op, input logic [DataW-1:0] a,
                            input logic [DataW-1:0] b, input int dep1, input int dep2);
        logic [DataW-1:0] pc, imm, v1, v2;
        int               nick;
        logic             done;
        pc   = $urandom & ~32'h3;
        imm  = $urandom;
        v1   = (dep1 >= 0) ? expData[dep1] : a;
        v2   = (dep2 >= 0) ? expData[dep2] : b;
        nick = 0;
        while (pending[nick] && nick < NickCnt - 1) nick++;
        {expData[nick], expTaken[nick], expTarget[nick]} = refExec(op, pc, imm, v1, v2);
        inValid  = 1'b1;
        inPc     = pc;
        inOp     = op;
        inImm    = imm;
        inNick   = NickW'(nick);
        src1Val  = v1;
        src1Nick = NickW'(dep1);
        src2Val  = v2;
        src2Nick = NickW'(dep2);
        done = 1'b0;
        while (!done) begin
            src1Ready = dep1 < 0 || !pending[dep1];  // producer already broadcast.
            src2Ready = dep2 < 0 || !pending[dep2];
            rdy       = stallMode ? ($urandom % 4 != 0) : 1'b1;
            done      = inReady && rdy;
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        int               prev;
        logic [DataW-1:0] a;
        void'($urandom(20568));
        rst       = 1'b1;
        rdy       = 1'b1;
        inValid   = 1'b0;
        inPc      = '0;
        inOp      = ADDI;
        inImm     = '0;
        inNick    = '0;
        src1Ready = 1'b0;
        src1Val   = '0;
        src1Nick  = '0;
        src2Ready = 1'b0;
        src2Val   = '0;
        src2Nick  = '0;
        expData   = '0;
        expTaken  = '0;
        expTarget = '0;
        stallMode = 1'b0;
        tbErrors  = 0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        if (!inReady || cdbValid) begin
            $display("after reset inReady is not high or cdbValid is not low");
            tbErrors++;
        end
        for (int k = int'(ADDI); k <= int'(AND); k++) begin
            repeat (4) sendInst(opcodeT'(k), $urandom, $urandom, -1, -1);
        end
        for (int k = int'(BEQ); k <= int'(BGEU); k++) begin
            a = $urandom;
            sendInst(opcodeT'(k), a, a, -1, -1);
            sendInst(opcodeT'(k), a, $urandom, -1, -1);
            sendInst(opcodeT'(k), a | 32'h8000_0000, $urandom >> 1, -1, -1);  // negative.
            sendInst(opcodeT'(k), $urandom >> 1, a | 32'h8000_0000, -1, -1);  // unsigned large.
        end
        for (int k = int'(LUI); k <= int'(JALR); k++) begin
            repeat (4) sendInst(opcodeT'(k), $urandom, $urandom, -1, -1);
        end
        repeat (40) begin
            sendInst(opcodeT'($urandom % (int'(AND) + 1)), $urandom, $urandom,
                     ($urandom % 2) ? pickDep() : -1, ($urandom % 2) ? pickDep() : -1);
        end
        stallMode = 1'b1;
        prev      = -1;
        repeat (32) begin
            sendInst(opcodeT'($urandom % (int'(AND) + 1)), $urandom, $urandom, prev, pickDep());
            prev = int'(inNick);  // chain keeps the station filling up.
        end
        stallMode = 1'b0;
        inValid   = 1'b0;
        rdy       = 1'b1;
        for (int c = 0; c < 40 * NickCnt && pending != '0; c++) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (!fullSeen) begin
            $display("inReady never fell while the burst filled the station");
            tbErrors++;
        end
        $display("errors: checker %0d, testbench %0d, never broadcast %0d",
                 errCount, tbErrors, $countones(pending));
        if (errCount == 0 && tbErrors == 0 && pending == '0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (40 * TotalInst + 200) @(posedge clk);
        $display("timeout: errors %0d, never broadcast %0d", errCount, $countones(pending));
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- tests/resultChecker.sv
`timescale 1ns/1ps

module resultChecker
    import execPkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cdbValid,
    input  logic [NickW-1:0]                 cdbNick,
    input  logic [DataW-1:0]                 cdbData,
    input  logic                             cdbTaken,
    input  logic [DataW-1:0]                 cdbTarget,
    input  logic                             inReady,
    input  logic                             acceptFire,
    input  logic [NickW-1:0]                 acceptNick,
    input  logic [(1<<NickW)-1:0][DataW-1:0] expData,
    input  logic [(1<<NickW)-1:0]            expTaken,
    input  logic [(1<<NickW)-1:0][DataW-1:0] expTarget,
    output logic [(1<<NickW)-1:0]            pending,
    output int                               errCount,
    output logic                             fullSeen
);

    // sampled mid cycle where bus and handshake are stable.
    always @(negedge clk) begin
        int bad;
        bad = 0;
        if (rst) begin
            pending  <= '0;
            errCount <= 0;
            fullSeen <= 1'b0;
        end else begin
            if (acceptFire) pending[acceptNick] <= 1'b1;
            if (!inReady) begin
                fullSeen <= 1'b1;
                if ($countones(pending) < RsDepth) begin  // only a full station may refuse.
                    $display("ERR %0t: inReady low with %0d nicks in flight",
                             $time, $countones(pending));
                    bad++;
                end
            end
            if (cdbValid) begin
                pending[cdbNick] <= 1'b0;
                if (!pending[cdbNick]) begin
                    $display("ERR %0t: nick %0d broadcast while not in flight", $time, cdbNick);
                    bad++;
                end else if (cdbData !== expData[cdbNick] || cdbTaken !== expTaken[cdbNick]
                             || cdbTarget !== expTarget[cdbNick]) begin
                    $display("ERR %0t: nick %0d got %h/%b/%h, expected %h/%b/%h", $time,
                             cdbNick, cdbData, cdbTaken, cdbTarget, expData[cdbNick],
                             expTaken[cdbNick], expTarget[cdbNick]);
                    bad++;
                end
            end
            errCount <= errCount + bad;
        end
    end

endmodule

//--- src/executeCluster.sv
`timescale 1ns/1ps

module executeCluster
    import execPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,

    input  logic             inValid,
    input  logic [DataW-1:0] inPc,
    input  opcodeT           inOp,
    input  logic [DataW-1:0] inImm,
    input  logic [NickW-1:0] inNick,
    input  logic             src1Ready,
    input  logic [DataW-1:0] src1Val,
    input  logic [NickW-1:0] src1Nick,
    input  logic             src2Ready,
    input  logic [DataW-1:0] src2Val,
    input  logic [NickW-1:0] src2Nick,
    output logic             inReady,

    output logic             cdbValid,
    output logic [NickW-1:0] cdbNick,
    output logic [DataW-1:0] cdbData,
    output logic             cdbTaken,
    output logic [DataW-1:0] cdbTarget
);

    logic [NumUnits-1:0]            unitBusy;
    logic [NumUnits-1:0]            issueEn;
    logic [DataW-1:0]               issuePc;
    opcodeT                         issueOp;
    logic [DataW-1:0]               issueImm;
    logic [NickW-1:0]               issueNick;
    logic [DataW-1:0]               issueRs1;
    logic [DataW-1:0]               issueRs2;
    logic [NumUnits-1:0]            resValid;
    logic [NumUnits-1:0][NickW-1:0] resNick;
    logic [NumUnits-1:0][DataW-1:0] resData;
    logic [NumUnits-1:0]            resTaken;
    logic [NumUnits-1:0][DataW-1:0] resTarget;
    logic [NumUnits-1:0]            grant;

    reservationStation rs0 (
        .clk(clk), .rst(rst), .rdy(rdy),
        .inValid(inValid), .inPc(inPc), .inOp(inOp), .inImm(inImm), .inNick(inNick),
        .src1Ready(src1Ready), .src1Val(src1Val), .src1Nick(src1Nick),
        .src2Ready(src2Ready), .src2Val(src2Val), .src2Nick(src2Nick),
        .inReady(inReady),
        .unitBusy(unitBusy), .issueEn(issueEn),
        .issuePc(issuePc), .issueOp(issueOp), .issueImm(issueImm),
        .issueNick(issueNick), .issueRs1(issueRs1), .issueRs2(issueRs2),
        .cdbValid(cdbValid), .cdbNick(cdbNick), .cdbData(cdbData)
    );

    // shared payload buses with issueEn picking the unit.
    for (genvar g = 0; g < NumUnits; g++) begin : units
        aluUnit unit0 (
            .clk(clk), .rst(rst), .rdy(rdy),
            .issueEn(issueEn[g]), .issuePc(issuePc), .issueOp(issueOp),
            .issueImm(issueImm), .issueNick(issueNick),
            .issueRs1(issueRs1), .issueRs2(issueRs2),
            .grant(grant[g]), .busy(unitBusy[g]),
            .resValid(resValid[g]), .resNick(resNick[g]), .resData(resData[g]),
            .resTaken(resTaken[g]), .resTarget(resTarget[g])
        );
    end

    cdbArbiter arb0 (
        .clk(clk), .rst(rst), .rdy(rdy),
        .resValid(resValid), .resNick(resNick), .resData(resData),
        .resTaken(resTaken), .resTarget(resTarget), .grant(grant),
        .cdbValid(cdbValid), .cdbNick(cdbNick), .cdbData(cdbData),
        .cdbTaken(cdbTaken), .cdbTarget(cdbTarget)
    );

endmodule

//--- src/cdbArbiter.sv
`timescale 1ns/1ps

module cdbArbiter
    import execPkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rdy,

    input  logic [NumUnits-1:0]             resValid,
    input  logic [NumUnits-1:0][NickW-1:0]  resNick,
    input  logic [NumUnits-1:0][DataW-1:0]  resData,
    input  logic [NumUnits-1:0]             resTaken,
    input  logic [NumUnits-1:0][DataW-1:0]  resTarget,
    output logic [NumUnits-1:0]             grant,

    output logic                            cdbValid,
    output logic [NickW-1:0]                cdbNick,
    output logic [DataW-1:0]                cdbData,
    output logic                            cdbTaken,
    output logic [DataW-1:0]                cdbTarget
);

    logic [$clog2(NumUnits)-1:0] ptr;
    int                          selIdx;
    logic                        found;

    // first valid unit at or after the pointer.
    always_comb begin
        found  = 1'b0;
        selIdx = 0;
        for (int k = 0; k < NumUnits; k++) begin
            if (!found && resValid[(int'(ptr) + k) % NumUnits]) begin
                found  = 1'b1;
                selIdx = (int'(ptr) + k) % NumUnits;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found && rdy) grant[selIdx] = 1'b1;  // no broadcast while stalled.
    end

    assign cdbValid  = found && rdy;
    assign cdbNick   = resNick[selIdx];
    assign cdbData   = resData[selIdx];
    assign cdbTaken  = resTaken[selIdx];
    assign cdbTarget = resTarget[selIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (rdy && found) begin
            ptr <= $clog2(NumUnits)'((selIdx + 1) % NumUnits);
        end
    end

endmodule

//--- src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit
    import execPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,

    input  logic             issueEn,
    input  logic [DataW-1:0] issuePc,
    input  opcodeT           issueOp,
    input  logic [DataW-1:0] issueImm,
    input  logic [NickW-1:0] issueNick,
    input  logic [DataW-1:0] issueRs1,
    input  logic [DataW-1:0] issueRs2,

    input  logic             grant,
    output logic             busy,
    output logic             resValid,
    output logic [NickW-1:0] resNick,
    output logic [DataW-1:0] resData,
    output logic             resTaken,
    output logic [DataW-1:0] resTarget
);

    logic [DataW-1:0] aluData;
    logic [DataW-1:0] targetNext;
    logic             takenNext;
    logic             brHit;
    logic [DataW-1:0] pcPlus4;
    logic [DataW-1:0] pcPlusImm;
    logic [4:0]       shImm;
    logic [4:0]       shRs2;

    assign pcPlus4   = issuePc + DataW'(4);
    assign pcPlusImm = issuePc + issueImm;
    assign shImm     = issueImm[4:0];  // rv32i shift amount.
    assign shRs2     = issueRs2[4:0];

    always_comb begin
        aluData    = '0;
        brHit      = 1'b0;
        takenNext  = NotJump;
        targetNext = pcPlus4;
        case (issueOp)
            LUI:   aluData = issueImm;
            AUIPC: aluData = pcPlusImm;
            JAL: begin
                aluData    = pcPlus4;
                takenNext  = Jump;
                targetNext = pcPlusImm;
            end
            JALR: begin
                aluData    = pcPlus4;
                takenNext  = Jump;
                targetNext = (issueRs1 + issueImm) & ~DataW'(1);
            end

            BEQ:  brHit = issueRs1 == issueRs2;
            BNE:  brHit = issueRs1 != issueRs2;
            BLT:  brHit = $signed(issueRs1) < $signed(issueRs2);
            BGE:  brHit = $signed(issueRs1) >= $signed(issueRs2);
            BLTU: brHit = issueRs1 < issueRs2;
            BGEU: brHit = issueRs1 >= issueRs2;

            ADDI:  aluData = issueRs1 + issueImm;
            SLTI:  aluData = {{(DataW-1){1'b0}}, $signed(issueRs1) < $signed(issueImm)};
            SLTIU: aluData = {{(DataW-1){1'b0}}, issueRs1 < issueImm};
            XORI:  aluData = issueRs1 ^ issueImm;
            ORI:   aluData = issueRs1 | issueImm;
            ANDI:  aluData = issueRs1 & issueImm;
            SLLI:  aluData = issueRs1 << shImm;
            SRLI:  aluData = issueRs1 >> shImm;
            SRAI:  aluData = $signed(issueRs1) >>> shImm;

            ADD:  aluData = issueRs1 + issueRs2;
            SUB:  aluData = issueRs1 - issueRs2;
            SLL:  aluData = issueRs1 << shRs2;
            SLT:  aluData = {{(DataW-1){1'b0}}, $signed(issueRs1) < $signed(issueRs2)};
            SLTU: aluData = {{(DataW-1){1'b0}}, issueRs1 < issueRs2};
            XOR:  aluData = issueRs1 ^ issueRs2;
            SRL:  aluData = issueRs1 >> shRs2;
            SRA:  aluData = $signed(issueRs1) >>> shRs2;
            OR:   aluData = issueRs1 | issueRs2;
            AND:  aluData = issueRs1 & issueRs2;
            default: aluData = '0;
        endcase
        if (brHit) begin
            takenNext  = Jump;
            targetNext = pcPlusImm;
        end
    end

    // a granted result frees the unit in the same cycle.
    assign busy = resValid && !grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else if (rdy) begin
            if (issueEn) resValid <= 1'b1;
            else if (grant) resValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueEn) begin
            resNick   <= issueNick;
            resData   <= aluData;
            resTaken  <= takenNext;
            resTarget <= targetNext;
        end
    end

endmodule

//--- src/reservationStation.sv
`timescale 1ns/1ps

module reservationStation
    import execPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,

    input  logic                inValid,
    input  logic [DataW-1:0]    inPc,
    input  opcodeT              inOp,
    input  logic [DataW-1:0]    inImm,
    input  logic [NickW-1:0]    inNick,
    input  logic                src1Ready,
    input  logic [DataW-1:0]    src1Val,
    input  logic [NickW-1:0]    src1Nick,
    input  logic                src2Ready,
    input  logic [DataW-1:0]    src2Val,
    input  logic [NickW-1:0]    src2Nick,
    output logic                inReady,

    input  logic [NumUnits-1:0] unitBusy,
    output logic [NumUnits-1:0] issueEn,
    output logic [DataW-1:0]    issuePc,
    output opcodeT              issueOp,
    output logic [DataW-1:0]    issueImm,
    output logic [NickW-1:0]    issueNick,
    output logic [DataW-1:0]    issueRs1,
    output logic [DataW-1:0]    issueRs2,

    input  logic                cdbValid,
    input  logic [NickW-1:0]    cdbNick,
    input  logic [DataW-1:0]    cdbData
);

    logic [RsDepth-1:0] entBusy;
    logic [RsDepth-1:0] rdy1;
    logic [RsDepth-1:0] rdy2;
    logic [DataW-1:0]   entPc   [RsDepth];
    opcodeT             entOp   [RsDepth];
    logic [DataW-1:0]   entImm  [RsDepth];
    logic [NickW-1:0]   entNick [RsDepth];
    logic [DataW-1:0]   val1    [RsDepth];
    logic [DataW-1:0]   val2    [RsDepth];
    logic [NickW-1:0]   nick1   [RsDepth];
    logic [NickW-1:0]   nick2   [RsDepth];

    logic [$clog2(RsDepth)-1:0]  freeIdx;
    logic [$clog2(RsDepth)-1:0]  readyIdx;
    logic [$clog2(NumUnits)-1:0] unitIdx;
    logic freeFound, readyFound, unitFound;
    logic accept, doIssue;
    logic newRdy1, newRdy2;
    logic [DataW-1:0] newVal1, newVal2;

    // incoming source may be on the bus this very cycle.
    function automatic logic [DataW:0] resolveSrc(input logic ready,
                                                  input logic [DataW-1:0] val,
                                                  input logic [NickW-1:0] nick);
        if (!ready && cdbValid && cdbNick == nick) begin
            return {1'b1, cdbData};
        end
        return {ready, val};
    endfunction

    assign {newRdy1, newVal1} = resolveSrc(src1Ready, src1Val, src1Nick);
    assign {newRdy2, newVal2} = resolveSrc(src2Ready, src2Val, src2Nick);

    // lowest index wins, so scan downwards.
    always_comb begin
        freeFound  = 1'b0;
        freeIdx    = '0;
        readyFound = 1'b0;
        readyIdx   = '0;
        for (int i = RsDepth - 1; i >= 0; i--) begin
            if (!entBusy[i]) begin
                freeFound = 1'b1;
                freeIdx   = $clog2(RsDepth)'(i);
            end
            if (entBusy[i] && rdy1[i] && rdy2[i]) begin
                readyFound = 1'b1;
                readyIdx   = $clog2(RsDepth)'(i);
            end
        end
    end

    always_comb begin
        unitFound = 1'b0;
        unitIdx   = '0;
        for (int u = NumUnits - 1; u >= 0; u--) begin
            if (!unitBusy[u]) begin
                unitFound = 1'b1;
                unitIdx   = $clog2(NumUnits)'(u);
            end
        end
    end

    assign inReady = freeFound;
    assign accept  = inValid && freeFound && rdy;
    assign doIssue = readyFound && unitFound && rdy;

    always_comb begin
        issueEn = '0;
        if (doIssue) issueEn[unitIdx] = 1'b1;
    end

    assign issuePc   = entPc[readyIdx];
    assign issueOp   = entOp[readyIdx];
    assign issueImm  = entImm[readyIdx];
    assign issueNick = entNick[readyIdx];
    assign issueRs1  = val1[readyIdx];
    assign issueRs2  = val2[readyIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            entBusy <= '0;
        end else if (rdy) begin
            if (doIssue) entBusy[readyIdx] <= 1'b0;  // freed as it leaves.
            if (accept) entBusy[freeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            // operand capture from the bus.
            for (int i = 0; i < RsDepth; i++) begin
                if (entBusy[i] && !rdy1[i] && cdbValid && cdbNick == nick1[i]) begin
                    rdy1[i] <= 1'b1;
                    val1[i] <= cdbData;
                end
                if (entBusy[i] && !rdy2[i] && cdbValid && cdbNick == nick2[i]) begin
                    rdy2[i] <= 1'b1;
                    val2[i] <= cdbData;
                end
            end
            if (accept) begin
                entPc[freeIdx]   <= inPc;
                entOp[freeIdx]   <= inOp;
                entImm[freeIdx]  <= inImm;
                entNick[freeIdx] <= inNick;
                rdy1[freeIdx]    <= newRdy1;
                val1[freeIdx]    <= newVal1;
                nick1[freeIdx]   <= src1Nick;
                rdy2[freeIdx]    <= newRdy2;
                val2[freeIdx]    <= newVal2;
                nick2[freeIdx]   <= src2Nick;
            end
        end
    end

endmodule

//--- src/execPkg.sv
package execPkg;

    localparam int DataW    = 32;   // data and pc width.
    localparam int NickW    = 4;    // rename tag width.
    localparam int NumUnits = 4;
    localparam int RsDepth  = 8;
    localparam int opW      = 6;

    // taken flag values.
    localparam logic Jump    = 1'b1;
    localparam logic NotJump = 1'b0;

    typedef enum logic [opW-1:0] {
        // upper immediate and jumps.
        LUI,
        AUIPC,
        JAL,
        JALR,
        // conditional branches.
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        // immediate alu ops.
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        // register alu ops.
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } opcodeT;

endpackage
